/* compile.f */
+incdir+source
source/bp_pkg.sv
source/branch_cache.sv
source/bht.sv
source/branch_decode.sv
source/branch_resolve.sv
source/branch_result.sv
source/branch_unit_top.sv
verification/tb_branch_unit.sv

/* verification/tb_branch_unit.sv */
`timescale 1ns/100ps

`include "bp_macros.svh"

module tb_branch_unit;
  import bp_pkg::*;

  // One applied cycle together with the responses the model expects for it
  typedef struct packed {
    pc_t      pc;                          // Fetch PC driven this cycle
    logic     en;                          // Pipeline advance level
    instr_t   instr;                       // Instruction for the PC held in IF/ID
    flags_t   flags;                       // Flags used to resolve that instruction
    counter_t exp_pred;                    // Counter expected for the fetch PC
    logic     exp_misp;                    // Expected redirect pulse
    logic     chk_redir;                   // A branch resolves so redirect_pc is checked
    pc_t      exp_redir;                   // Expected target or fall-through PC
  } row_t;

  localparam instr_t alu_word = 16'h1234;  // Any opcode other than a branch

  logic     clk;
  logic     rst_n;
  pc_t      fetch_pc;
  logic     fetch_en;
  instr_t   id_instr;
  flags_t   flags;
  counter_t prediction;
  logic     pred_taken;
  logic     mispredict;
  pc_t      redirect_pc;

  row_t        rows [$];                   // Stimulus and expected values
  logic        m_valid [8];                // Reference copy of the table
  tag_t        m_tag [8];
  counter_t    m_cnt [8];
  logic        id_valid;                   // Reference copy of IF/ID
  pc_t         id_pc;
  counter_t    id_pred;
  instr_t      held_instr;                 // Instruction fetched with id_pc
  logic [31:0] rng;                        // Xorshift state
  int          wait_cycles;

  branch_unit_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_pc    (fetch_pc),
    .fetch_en    (fetch_en),
    .id_instr    (id_instr),
    .flags       (flags),
    .prediction  (prediction),
    .pred_taken  (pred_taken),
    .mispredict  (mispredict),
    .redirect_pc (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                // 40 ns period
  end

  initial begin
    rst_n    = 1'b0;
    fetch_pc = '0;
    fetch_en = 1'b0;
    id_instr = '0;
    flags    = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;                         // Released after ten cycles
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic instr_t branch_word(input cond_t cond, input logic [8:0] offset);
    return {`BP_BR_OPCODE, cond, offset};  // Opcode, condition, halfword offset
  endfunction

  function automatic logic cond_holds(input cond_t cond, input flags_t f);
    case (cond)
      neq:     return !f.z;
      eq:      return f.z;
      gt:      return !f.z && !f.n;
      lt:      return f.n;
      gte:     return f.z || !f.n;
      lte:     return f.n || f.z;
      ovfl:    return f.v;
      default: return 1'b1;                // Unconditional
    endcase
  endfunction

  // Weak not taken ignores the tag, every other state falls back on a miss
  function automatic counter_t next_count(input counter_t base, input logic hit,
                                          input logic taken);
    if (base == weak_nt) return taken ? weak_t : strong_nt;
    if (!hit) return weak_nt;
    if (taken) return (base == strong_t) ? strong_t : counter_t'(base + 1);
    return (base == strong_nt) ? strong_nt : counter_t'(base - 1);
  endfunction

  // Appends one cycle, instr is the word at pc and shows up in IF/ID next cycle
  task automatic add_row(input pc_t pc, input logic en, input instr_t instr,
                         input flags_t fl);
    row_t   r;
    index_t ix;
    logic   hit;
    logic   taken;
    pc_t    next;
    r.pc        = pc;
    r.en        = en;
    r.instr     = held_instr;
    r.flags     = fl;
    ix          = pc[3:1];
    hit         = m_valid[ix] && (m_tag[ix] == pc[15:4]);
    r.exp_pred  = hit ? m_cnt[ix] : weak_nt;   // Lookup before this cycle's write
    r.chk_redir = id_valid && en && (held_instr[15:12] == `BP_BR_OPCODE);
    taken       = cond_holds(cond_t'(held_instr[11:9]), fl);
    next        = id_pc + 16'd2;
    r.exp_misp  = r.chk_redir && (id_pred[1] != taken);
    r.exp_redir = taken ? next + pc_t'(2 * $signed(held_instr[8:0])) : next;
    if (r.chk_redir) begin
      ix         = id_pc[3:1];
      hit        = m_valid[ix] && (m_tag[ix] == id_pc[15:4]);
      m_cnt[ix]  = next_count(id_pred, hit, taken);
      m_valid[ix] = 1'b1;
      m_tag[ix]  = id_pc[15:4];              // Entry now owned by the resolved PC
    end
    if (en) begin
      id_valid   = 1'b1;
      id_pc      = pc;
      id_pred    = r.exp_pred;
      held_instr = instr;
    end
    rows.push_back(r);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////
  task automatic build_table();
    pc_t pc;
    for (int i = 0; i < 8; i++) m_valid[i] = 1'b0;
    id_valid   = 1'b0;
    id_pc      = '0;
    id_pred    = weak_nt;
    held_instr = alu_word;
    rng        = 32'hcd25;
    for (int i = 0; i < 4; i++) add_row(pc_t'(16'h0100 + 6 * i), 1'b1, alu_word, '0);
    add_row(16'h0010, 1'b1, branch_word(eq, 9'd5), '0);      // Not taken with z low
    for (int i = 0; i < 9; i++) begin                           // Walk up, then down
      add_row(16'h0024, 1'b1, branch_word(i < 4 ? uncond : ovfl, 9'h1fd), '0);
      add_row(16'h0100, 1'b1, alu_word, '0);
    end
    for (int i = 0; i < 2; i++) begin                           // Same index, other tag
      add_row(16'h1024, 1'b1, branch_word(uncond, 9'd7), '0);
      add_row(16'h0100, 1'b1, alu_word, '0);
    end
    add_row(16'h0024, 1'b1, branch_word(uncond, 9'd2), '0);  // Steals the entry
    add_row(16'h1024, 1'b1, branch_word(uncond, 9'd7), '0);  // Stale strong taken
    add_row(16'h0100, 1'b1, alu_word, '0);
    add_row(16'h1024, 1'b1, alu_word, '0);
    for (int i = 0; i < 24; i++) begin                          // Every condition
      rng = xorshift(rng);
      pc  = pc_t'(16'h0200 + {rng[4:1], 1'b0});
      add_row(pc, 1'b1, branch_word(cond_t'(3'(i)), rng[24:16]), flags_t'(rng[10:8]));
    end
    add_row(16'h0046, 1'b1, branch_word(uncond, 9'h1f0), '0);
    for (int i = 0; i < 3; i++) add_row(16'h0046, 1'b0, alu_word, '0);  // Stalled
    add_row(16'h0100, 1'b1, alu_word, '0);                   // Resolves exactly once
    add_row(16'h0046, 1'b1, alu_word, '0);
    for (int i = 0; i < 2; i++) begin
      add_row(16'h003a, 1'b1, branch_word(uncond, 9'd3), '0);
      add_row(16'h0100, 1'b1, alu_word, '0);
    end
    for (int i = 0; i < 3; i++) add_row(16'h003a, 1'b1, alu_word, '0);  // Non branches
    add_row(16'h0100, 1'b1, alu_word, '0);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("sim failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Apply and compare
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    build_table();
    wait_cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles > 50) begin
        $display("reset was never released");
        $display("sim failed");
        $fatal(1, "reset wait timed out");
      end
    end
    for (int k = 0; k < rows.size(); k++) begin
      @(posedge clk);
      fetch_pc <= rows[k].pc;
      fetch_en <= rows[k].en;
      id_instr <= rows[k].instr;
      flags    <= rows[k].flags;
      @(negedge clk);                        // Outputs settled mid cycle
      check($sformatf("prediction row %0d", k), prediction, rows[k].exp_pred);
      check($sformatf("pred_taken row %0d", k), pred_taken, rows[k].exp_pred[1]);
      check($sformatf("mispredict row %0d", k), mispredict, rows[k].exp_misp);
      if (rows[k].chk_redir) begin
        check($sformatf("redirect_pc row %0d", k), redirect_pc, rows[k].exp_redir);
      end
    end
    $display("sim passed");
    $finish;
  end

endmodule

/* source/branch_unit_top.sv */
`timescale 1ns/100ps

module branch_unit_top (
  input  logic             clk,
  input  logic             rst_n,
  input  bp_pkg::pc_t      fetch_pc,     // PC of the instruction being fetched
  input  logic             fetch_en,     // High when the pipeline is not stalled
  input  bp_pkg::instr_t   id_instr,     // Instruction for the PC held in IF/ID
  input  bp_pkg::flags_t   flags,        // Current flag register
  output bp_pkg::counter_t prediction,   // Counter for the fetch PC
  output logic             pred_taken,   // Predicted direction for the fetch PC
  output logic             mispredict,   // One cycle redirect pulse
  output bp_pkg::pc_t      redirect_pc   // Correct PC while mispredict is high
);
  import bp_pkg::*;

  if_id_t       if_id;                   // Fetch to decode pipeline register
  branch_info_t info;                    // Decoded branch fields
  resolve_t     res;                     // Resolved outcome
  logic         bp_wen;                  // Table update strobe

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      if_id <= '0;                       // Nothing in flight after reset
    end else if (fetch_en) begin
      if_id.valid      <= 1'b1;
      if_id.pc         <= fetch_pc;
      if_id.prediction <= prediction;    // Remember what fetch was told
    end
  end

  bht u_bht (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_pc     (fetch_pc),
    .if_id        (if_id),
    .actual_taken (res.actual_taken),
    .wen          (bp_wen),
    .prediction   (prediction),
    .pred_taken   (pred_taken)
  );

  branch_decode u_decode (
    .instr (id_instr),
    .info  (info)
  );

  branch_resolve u_resolve (
    .info  (info),
    .pc    (if_id.pc),
    .valid (if_id.valid),
    .flags (flags),
    .res   (res)
  );

  branch_result u_result (
    .res         (res),
    .predicted   (if_id.prediction),
    .fetch_en    (fetch_en),
    .bp_wen      (bp_wen),
    .mispredict  (mispredict),
    .redirect_pc (redirect_pc)
  );

endmodule

/* source/branch_result.sv */
`timescale 1ns/100ps

module branch_result (
  input  bp_pkg::resolve_t res,          // Resolved branch from the execute role
  input  bp_pkg::counter_t predicted,    // Counter used when the branch was fetched
  input  logic             fetch_en,     // Pipeline advances this cycle
  output logic             bp_wen,       // Table update strobe
  output logic             mispredict,   // One cycle redirect request
  output bp_pkg::pc_t      redirect_pc   // Correct PC to fetch next
);
  import bp_pkg::*;

  logic pred_dir;                        // Direction the fetch stage followed
  logic dir_wrong;                       // Prediction disagrees with the outcome

  ////////////////////////////////////////////////////////////////////////////
  // Compare and redirect
  ////////////////////////////////////////////////////////////////////////////
  assign pred_dir  = predicted[1];       // Upper counter bit holds the direction
  assign dir_wrong = pred_dir ^ res.actual_taken;

  // A stalled cycle must not update or redirect so the branch resolves once
  assign bp_wen = res.is_branch && fetch_en;

  // Non branches have actual_taken low yet may carry a taken prediction
  assign mispredict = res.is_branch && fetch_en && dir_wrong;

  // Only meaningful while mispredict is high
  assign redirect_pc = res.actual_taken ? res.target : res.fall_through;

endmodule

/* source/branch_resolve.sv */
`timescale 1ns/100ps

`include "bp_macros.svh"

module branch_resolve (
  input  bp_pkg::branch_info_t info,   // Decoded branch fields
  input  bp_pkg::pc_t          pc,     // PC of the instruction in IF/ID
  input  logic                 valid,  // IF/ID holds a real instruction
  input  bp_pkg::flags_t       flags,  // Current flag register
  output bp_pkg::resolve_t     res     // Outcome and both candidate PCs
);
  import bp_pkg::*;

  logic cond_met;                      // Condition holds for these flags
  logic is_branch;                     // Branch qualified by IF/ID valid
  pc_t  offset_bytes;                  // Offset scaled to bytes and widened
  pc_t  next_pc;                       // Sequential successor

  ////////////////////////////////////////////////////////////////////////////
  // Condition evaluation
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (info.cond)
      neq:     cond_met = !flags.z;
      eq:      cond_met = flags.z;
      gt:      cond_met = !flags.z && !flags.n;  // Strictly positive result
      lt:      cond_met = flags.n;
      gte:     cond_met = flags.z || !flags.n;
      lte:     cond_met = flags.n || flags.z;
      ovfl:    cond_met = flags.v;
      uncond:  cond_met = 1'b1;                  // Always taken
      default: cond_met = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Target arithmetic
  ////////////////////////////////////////////////////////////////////////////
  // Sign extend and append a zero bit to turn halfwords into bytes
  assign offset_bytes = {{(`BP_PC_W-`BP_OFFSET_W-1){info.offset[`BP_OFFSET_W-1]}},
                         info.offset, 1'b0};
  assign next_pc      = pc + pc_t'(2);           // Instructions are two bytes wide

  assign is_branch = info.is_branch && valid;    // An empty IF/ID slot resolves nothing

  assign res.is_branch    = is_branch;
  assign res.actual_taken = is_branch && cond_met;  // Non branches never count as taken
  assign res.target       = next_pc + offset_bytes;
  assign res.fall_through = next_pc;

endmodule

/* source/branch_decode.sv */
`timescale 1ns/100ps

`include "bp_macros.svh"

module branch_decode (
  input  bp_pkg::instr_t       instr,  // Instruction held for the IF/ID PC
  output bp_pkg::branch_info_t info    // Branch fields pulled out of it
);
  import bp_pkg::*;

  logic [`BP_OPC_W-1:0]    opcode;     // Top nibble of the word
  logic [`BP_COND_W-1:0]   cond_bits;  // Raw condition field
  offset_t                 offset;     // Raw offset field

  ////////////////////////////////////////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////////////////////////////////////////
  // Layout is opcode in 15 to 12, condition in 11 to 9 and offset in 8 to 0
  assign opcode    = instr[`BP_PC_W-1 -: `BP_OPC_W];
  assign cond_bits = instr[`BP_PC_W-`BP_OPC_W-1 -: `BP_COND_W];
  assign offset    = instr[`BP_OFFSET_W-1:0];

  // Only the branch opcode makes this a branch
  assign info.is_branch = (opcode == `BP_BR_OPCODE);

  // All eight codes are defined so the cast cannot land outside the enum
  assign info.cond = cond_t'(cond_bits);

  // Offset passes through unscaled and the resolve block doubles it
  assign info.offset = offset;

endmodule

/* source/bht.sv */
`timescale 1ns/100ps

`include "bp_macros.svh"

module bht (
  input  logic             clk,
  input  logic             rst_n,
  input  bp_pkg::pc_t      fetch_pc,      // PC presented by the fetch stage
  input  bp_pkg::if_id_t   if_id,         // Branch waiting in the IF/ID register
  input  logic             actual_taken,  // Resolved outcome of that branch
  input  logic             wen,           // Table update strobe from the result block
  output bp_pkg::counter_t prediction,    // Counter for the fetch PC
  output logic             pred_taken     // Predicted direction for the fetch PC
);
  import bp_pkg::*;

  index_t     fetch_index;                // Entry addressed by the fetch PC
  tag_t       fetch_tag;                  // Tag of the fetch PC
  index_t     id_index;                   // Entry addressed by the IF/ID PC
  tag_t       id_tag;                     // Tag of the IF/ID PC
  bht_entry_t fetch_entry;                // Stored entry for the fetch PC
  bht_entry_t id_entry;                   // Stored entry for the IF/ID PC
  bht_entry_t wr_entry;                   // Entry written back after resolution
  logic       fetch_hit;                  // Fetch PC owns a valid entry
  logic       id_hit;                     // IF/ID PC owns a valid entry

  // Split both PCs into index and tag
  assign fetch_index = fetch_pc[`BP_INDEX_W:1];
  assign fetch_tag   = fetch_pc[`BP_PC_W-1 -: `BP_TAG_W];
  assign id_index    = if_id.pc[`BP_INDEX_W:1];
  assign id_tag      = if_id.pc[`BP_PC_W-1 -: `BP_TAG_W];

  branch_cache u_cache (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_index_curr (fetch_index),
    .rd_index_prev (id_index),
    .wr_index      (id_index),            // The update always lands on the IF/ID entry
    .wen           (wen),
    .wr_data       (wr_entry),
    .rd_data_curr  (fetch_entry),
    .rd_data_prev  (id_entry)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Fetch side lookup
  ////////////////////////////////////////////////////////////////////////////
  // The valid bit is tested first so a cleared entry never compares its tag
  assign fetch_hit  = fetch_entry.valid && (fetch_entry.tag == fetch_tag);
  assign prediction = fetch_hit ? fetch_entry.counter : weak_nt;  // Miss reads as weak not taken
  assign pred_taken = prediction[1];      // Upper counter bit is the direction

  ////////////////////////////////////////////////////////////////////////////
  // Counter update for the IF/ID branch
  ////////////////////////////////////////////////////////////////////////////
  assign id_hit = id_entry.valid && (id_entry.tag == id_tag);

  always_comb begin
    wr_entry.valid = 1'b1;                // A resolved branch always claims its entry
    wr_entry.tag   = id_tag;              // Entry now belongs to the IF/ID PC
    case (if_id.prediction)
      // Weak not taken moves without looking at the tag
      weak_nt:   wr_entry.counter = actual_taken ? weak_t : strong_nt;
      strong_nt: wr_entry.counter = (id_hit && actual_taken) ? weak_nt : (id_hit ? strong_nt : weak_nt);
      weak_t:    wr_entry.counter = (id_hit && actual_taken) ? strong_t : weak_nt;
      strong_t:  wr_entry.counter = !id_hit ? weak_nt : (actual_taken ? strong_t : weak_t);
      default:   wr_entry.counter = weak_nt;  // Fall back to the reset state
    endcase
  end

  // Each write carries a known counter
  wr_counter_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    wen |-> !$isunknown(wr_entry.counter)
  ) else $error("bht update with unknown counter");

endmodule

/* source/branch_cache.sv */
`timescale 1ns/100ps

`include "bp_macros.svh"

module branch_cache (
  input  logic               clk,
  input  logic               rst_n,
  input  bp_pkg::index_t     rd_index_curr,   // Index of the PC being fetched
  input  bp_pkg::index_t     rd_index_prev,   // Index of the PC held in IF/ID
  input  bp_pkg::index_t     wr_index,        // Index of the entry to rewrite
  input  logic               wen,             // Write strobe for one clock
  input  bp_pkg::bht_entry_t wr_data,         // New entry contents
  output bp_pkg::bht_entry_t rd_data_curr,    // Entry seen by the fetch side
  output bp_pkg::bht_entry_t rd_data_prev     // Entry seen by the decode side
);
  import bp_pkg::*;

  bht_entry_t mem [`BP_ENTRIES];              // The table storage

  ////////////////////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////////////////////
  // Both reads are combinational so the fetch prediction has no latency
  assign rd_data_curr = mem[rd_index_curr];   // Fetch PC lookup
  assign rd_data_prev = mem[rd_index_prev];   // IF/ID PC lookup for the update

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `BP_ENTRIES; i++) begin
        mem[i].valid <= 1'b0;                 // Every entry starts out empty
      end
    end else if (wen) begin
      mem[wr_index] <= wr_data;               // Whole entry is replaced at once
    end
  end

  // A write to an unknown address would corrupt an arbitrary entry
  wr_index_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    wen |-> !$isunknown(wr_index)
  ) else $error("branch_cache write with unknown index %b", wr_index);

endmodule

/* source/bp_pkg.sv */
`include "bp_macros.svh"

package bp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Plain vector types
  ////////////////////////////////////////////////////////////////////////////
  typedef logic [`BP_PC_W-1:0]              pc_t;      // Program counter
  typedef logic [`BP_PC_W-1:0]              instr_t;   // Instruction word
  typedef logic [`BP_TAG_W-1:0]             tag_t;     // Upper PC bits kept with an entry
  typedef logic [`BP_INDEX_W-1:0]           index_t;   // Table address
  typedef logic signed [`BP_OFFSET_W-1:0]   offset_t;  // Branch offset counted in halfwords

  // Two-bit saturating counter, the upper bit is the taken prediction
  typedef enum logic [1:0] {
    strong_nt = 2'd0,
    weak_nt   = 2'd1,
    weak_t    = 2'd2,
    strong_t  = 2'd3
  } counter_t;

  // Branch condition codes as encoded in bits 11 to 9
  typedef enum logic [`BP_COND_W-1:0] {
    neq    = 3'd0,
    eq     = 3'd1,
    gt     = 3'd2,
    lt     = 3'd3,
    gte    = 3'd4,
    lte    = 3'd5,
    ovfl   = 3'd6,
    uncond = 3'd7
  } cond_t;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles passed between the blocks
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic z;                 // Zero flag
    logic v;                 // Overflow flag
    logic n;                 // Negative flag
  } flags_t;

  typedef struct packed {
    logic     valid;         // Entry has been written since reset
    tag_t     tag;           // Tag of the branch that owns the entry
    counter_t counter;       // Saturating counter state
  } bht_entry_t;

  typedef struct packed {
    logic     valid;         // IF/ID holds a fetched instruction
    pc_t      pc;            // PC of that instruction
    counter_t prediction;    // Counter read when it was fetched
  } if_id_t;

  typedef struct packed {
    logic    is_branch;      // Conditional branch opcode seen
    cond_t   cond;           // Condition to test against the flags
    offset_t offset;         // Signed offset in halfwords
  } branch_info_t;

  typedef struct packed {
    logic is_branch;         // Valid branch sits in IF/ID
    logic actual_taken;      // Condition holds for the current flags
    pc_t  target;            // Taken destination
    pc_t  fall_through;      // Next sequential PC
  } resolve_t;

endpackage

/* source/bp_macros.svh */
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Widths and sizes of the branch prediction subsystem
////////////////////////////////////////////////////////////////////////////

`define BP_PC_W      16     // Width of a PC and of an instruction word
`define BP_INDEX_W   3      // Table index taken from PC bits 3 to 1
`define BP_ENTRIES   8      // Number of table entries
`define BP_TAG_W     12     // Tag taken from PC bits 15 to 4

// Instruction fields of a conditional branch
`define BP_OPC_W     4      // Opcode sits in the top nibble
`define BP_COND_W    3      // Condition code in bits 11 to 9
`define BP_OFFSET_W  9      // Signed halfword offset in bits 8 to 0

`define BP_BR_OPCODE 4'hC   // Opcode of a conditional branch

`endif
